// File: hw/mem_sys_pkg.sv
// Shared constants for the data cache and the banked main memory.
// Modules import it inside their body; port lists use scoped names.

package mem_sys_pkg;

   // Address and word fields
   localparam int addr_width  = 16;
   localparam int data_width  = 16;
   localparam int tag_width   = 5;
   localparam int index_width = 8;

   // Cache geometry
   localparam int words_per_line = 4;
   localparam int offset_width   = $clog2(words_per_line);
   localparam int num_sets       = 1 << index_width;

   // Main memory
   localparam int num_banks        = 4;
   localparam int bank_width       = $clog2(num_banks);
   localparam int mem_words        = 1 << (addr_width - 1);
   localparam int mem_latency      = 2;
   localparam int bank_busy_cycles = 4;
   localparam int busy_width       = $clog2(bank_busy_cycles + 1);

   // Controller FSM states
   localparam int state_width = 4;
   localparam logic [state_width-1:0] idle             = 4'd0;
   localparam logic [state_width-1:0] compare          = 4'd1;
   localparam logic [state_width-1:0] writeback        = 4'd2;
   localparam logic [state_width-1:0] mem_read         = 4'd3;
   localparam logic [state_width-1:0] fill             = 4'd4;
   localparam logic [state_width-1:0] write_after_fill = 4'd5;
   localparam logic [state_width-1:0] done_hit         = 4'd6;
   localparam logic [state_width-1:0] done_fill        = 4'd7;
   localparam logic [state_width-1:0] error            = 4'd8;

endpackage

// File: hw/cache_way.sv
// One way of the two-way data cache: tag, valid, dirty and line storage.
// Lookups are combinational on index/offset; updates happen on enable with write.
// comp high is a compare access, comp low a fill of one word.

`timescale 1ns/10ps

module cache_way (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  enable,
   input  logic                                  comp,
   input  logic                                  write,
   input  logic [mem_sys_pkg::tag_width-1:0]     tag_in,
   input  logic [mem_sys_pkg::index_width-1:0]   index,
   input  logic [mem_sys_pkg::offset_width-1:0]  offset,
   input  logic [mem_sys_pkg::data_width-1:0]    cache_data_in,
   output logic [mem_sys_pkg::tag_width-1:0]     tag_out,
   output logic [mem_sys_pkg::data_width-1:0]    data_out,
   output logic                                  hit,
   output logic                                  dirty,
   output logic                                  valid
);
   import mem_sys_pkg::*;

   logic [tag_width-1:0]  tags      [num_sets];
   logic [data_width-1:0] lines     [num_sets][words_per_line];
   logic [num_sets-1:0]   valid_bits;
   logic [num_sets-1:0]   dirty_bits;
   logic                  cmp_we;
   logic                  fill_we;

   assign tag_out  = tags[index];
   assign data_out = lines[index][offset];
   assign valid    = valid_bits[index];
   assign dirty    = dirty_bits[index];
   assign hit      = enable & comp & valid & (tag_out == tag_in);

   // A compare write only lands on a hit
   assign cmp_we  = enable & write & comp & hit;
   assign fill_we = enable & write & ~comp;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (cmp_we) begin
         dirty_bits[index] <= 1'b1;
      end else if (fill_we) begin
         valid_bits[index] <= 1'b1;
         dirty_bits[index] <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (cmp_we || fill_we) begin
         lines[index][offset] <= cache_data_in;
      end
      if (fill_we) begin
         tags[index] <= tag_in;
      end
   end

endmodule

// File: hw/bank_memory.sv
// Slow four-bank main memory behind the cache.
// A bank stays busy for a few cycles after each accepted access, and
// mem_stall reports the addressed bank as busy. Read data appears a fixed
// number of cycles after acceptance, so reads to other banks overlap.

`timescale 1ns/10ps

module bank_memory (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [mem_sys_pkg::addr_width-1:0]  mem_addr,
   input  logic [mem_sys_pkg::data_width-1:0]  mem_data_in,
   input  logic                                mem_rd,
   input  logic                                mem_wr,
   output logic [mem_sys_pkg::data_width-1:0]  mem_data_out,
   output logic                                mem_stall
);
   import mem_sys_pkg::*;

   logic [data_width-1:0] mem      [mem_words];
   logic [busy_width-1:0] busy_cnt [num_banks];
   logic [data_width-1:0] rd_data  [mem_latency];
   logic [mem_latency-1:0] rd_v;
   logic [bank_width-1:0] bank;
   logic [addr_width-2:0] word;
   logic                  accept;

   assign bank      = mem_addr[1 +: bank_width];
   assign word      = mem_addr[addr_width-1:1];
   assign mem_stall = (busy_cnt[bank] != '0);
   assign accept    = (mem_rd | mem_wr) & ~mem_stall;

   initial begin
      for (int i = 0; i < mem_words; i++) begin
         mem[i] = '0;
      end
   end

   always @(posedge clk) begin
      if (accept && mem_wr) begin
         mem[word] <= mem_data_in;
      end
   end

   // Busy countdown per bank
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int b = 0; b < num_banks; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < num_banks; b++) begin
            if (accept && (bank == b[bank_width-1:0])) begin
               busy_cnt[b] <= busy_width'(bank_busy_cycles);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // Read latency pipe
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_v <= '0;
      end else begin
         rd_v <= {rd_v[mem_latency-2:0], accept & mem_rd};
      end
   end

   always_ff @(posedge clk) begin
      rd_data[0] <= mem[word];
      for (int s = 1; s < mem_latency; s++) begin
         rd_data[s] <= rd_data[s-1];
      end
   end

   assign mem_data_out = rd_v[mem_latency-1] ? rd_data[mem_latency-1] : '0;

endmodule

// File: hw/cache_controller.sv
// Control FSM for the two-way write-back cache.
// Sequences compare, dirty write-back, line refill and the done cycle, and
// holds the victim choice for a miss. Reads to memory are pipelined and each
// returning word is written into the victim way as it arrives.

`timescale 1ns/10ps

module cache_controller (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic [mem_sys_pkg::addr_width-1:0]    addr,
   input  logic [mem_sys_pkg::data_width-1:0]    data_in,
   input  logic                                  rd,
   input  logic                                  wr,
   input  logic [mem_sys_pkg::tag_width-1:0]     tag_out0,
   input  logic [mem_sys_pkg::data_width-1:0]    data_out0,
   input  logic                                  hit0,
   input  logic                                  dirty0,
   input  logic                                  valid0,
   input  logic [mem_sys_pkg::tag_width-1:0]     tag_out1,
   input  logic [mem_sys_pkg::data_width-1:0]    data_out1,
   input  logic                                  hit1,
   input  logic                                  dirty1,
   input  logic                                  valid1,
   input  logic [mem_sys_pkg::data_width-1:0]    mem_data_out,
   input  logic                                  mem_stall,
   output logic                                  enable,
   output logic                                  comp,
   output logic                                  write0,
   output logic                                  write1,
   output logic [mem_sys_pkg::tag_width-1:0]     tag_in,
   output logic [mem_sys_pkg::index_width-1:0]   index,
   output logic [mem_sys_pkg::offset_width-1:0]  offset,
   output logic [mem_sys_pkg::data_width-1:0]    cache_data_in,
   output logic [mem_sys_pkg::addr_width-1:0]    mem_addr,
   output logic [mem_sys_pkg::data_width-1:0]    mem_data_in,
   output logic                                  mem_rd,
   output logic                                  mem_wr,
   output logic [mem_sys_pkg::data_width-1:0]    data_out,
   output logic                                  done,
   output logic                                  stall,
   output logic                                  cache_hit,
   output logic                                  err
);
   import mem_sys_pkg::*;

   logic [state_width-1:0]  state;
   logic [state_width-1:0]  state_next;
   logic                    victim;
   logic                    victim_way;
   logic [offset_width-1:0] wb_cnt;
   logic [offset_width-1:0] rd_cnt;
   logic [mem_latency-1:0]  pipe_v;
   logic [offset_width-1:0] pipe_off [mem_latency];
   logic [offset_width-1:0] fill_off;
   logic [tag_width-1:0]    req_tag;
   logic [index_width-1:0]  req_index;
   logic [tag_width-1:0]    victim_tag;
   logic                    any_hit;
   logic                    bad_req;
   logic                    miss_victim;
   logic                    victim_dirty;
   logic                    mem_accept;
   logic                    fill_we;
   logic                    fill_last;
   logic                    cmp_write;
   logic                    refilling;

   assign req_tag   = addr[addr_width-1 -: tag_width];
   assign req_index = addr[offset_width+1 +: index_width];
   assign any_hit   = hit0 | hit1;
   assign bad_req   = (rd & wr) | addr[0];

   // First invalid way wins, else the round-robin bit
   assign miss_victim  = ~valid0 ? 1'b0 : (~valid1 ? 1'b1 : victim_way);
   assign victim_dirty = miss_victim ? (valid1 & dirty1) : (valid0 & dirty0);
   assign victim_tag   = victim ? tag_out1 : tag_out0;

   assign mem_accept = (mem_rd | mem_wr) & ~mem_stall;
   assign refilling  = (state == mem_read) || (state == fill);
   assign fill_off   = pipe_off[mem_latency-1];
   assign fill_we    = pipe_v[mem_latency-1];
   assign fill_last  = fill_we && (fill_off == offset_width'(words_per_line - 1));

   always_comb begin
      state_next = state;
      case (state)
         idle: begin
            if (rd || wr) begin
               state_next = bad_req ? error : compare;
            end
         end
         compare: begin
            if (any_hit) begin
               state_next = done_hit;
            end else begin
               state_next = victim_dirty ? writeback : mem_read;
            end
         end
         writeback: begin
            if (mem_accept && (&wb_cnt)) begin
               state_next = mem_read;
            end
         end
         mem_read: begin
            if (mem_accept && (&rd_cnt)) begin
               state_next = fill;
            end
         end
         fill: begin
            if (fill_last) begin
               state_next = wr ? write_after_fill : done_fill;
            end
         end
         write_after_fill: state_next = done_fill;
         default: state_next = idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= idle;
         victim     <= 1'b0;
         victim_way <= 1'b0;
         wb_cnt     <= '0;
         rd_cnt     <= '0;
         pipe_v     <= '0;
      end else begin
         state  <= state_next;
         pipe_v <= {pipe_v[mem_latency-2:0], (state == mem_read) & mem_accept};
         if (state == compare && !any_hit) begin
            victim <= miss_victim;
         end
         if (state == done_hit || state == done_fill) begin
            victim_way <= ~victim_way;
         end
         if (state == writeback && mem_accept) begin
            wb_cnt <= wb_cnt + 1'b1;
         end
         if (state == mem_read && mem_accept) begin
            rd_cnt <= rd_cnt + 1'b1;
         end
      end
   end

   // Word offsets of reads in flight, aligned with the memory latency
   always_ff @(posedge clk) begin
      pipe_off[0] <= rd_cnt;
      for (int s = 1; s < mem_latency; s++) begin
         pipe_off[s] <= pipe_off[s-1];
      end
   end

   // Cache way side
   assign enable    = (state != idle) && (state != error);
   assign comp      = (state == compare) || (state == write_after_fill) ||
                      (state == done_hit) || (state == done_fill);
   assign cmp_write = ((state == compare) & wr) | (state == write_after_fill);
   assign write0    = cmp_write | (fill_we & ~victim);
   assign write1    = cmp_write | (fill_we & victim);
   assign tag_in    = req_tag;
   assign index     = req_index;

   always_comb begin
      if (state == writeback) begin
         offset = wb_cnt;
      end else if (refilling) begin
         offset = fill_off;
      end else begin
         offset = addr[1 +: offset_width];
      end
   end

   assign cache_data_in = refilling ? mem_data_out : data_in;

   // Memory side; write-back goes out under the victim's tag
   assign mem_wr      = (state == writeback);
   assign mem_rd      = (state == mem_read);
   assign mem_data_in = victim ? data_out1 : data_out0;
   assign mem_addr    = (state == writeback) ? {victim_tag, req_index, wb_cnt, 1'b0}
                                             : {req_tag, req_index, rd_cnt, 1'b0};

   // Client side
   assign data_out  = hit1 ? data_out1 : data_out0;
   assign done      = (state == done_hit) || (state == done_fill) || (state == error);
   assign cache_hit = (state == done_hit);
   assign err       = (state == error);
   assign stall     = (state != idle) && !done;

endmodule

// File: hw/mem_system.sv
// Top level of the data memory system: two cache ways, the controller and
// the four-bank main memory. A client holds rd or wr with addr and data_in
// until the one-cycle done pulse.

`timescale 1ns/10ps

module mem_system (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [mem_sys_pkg::addr_width-1:0]  addr,
   input  logic [mem_sys_pkg::data_width-1:0]  data_in,
   input  logic                                rd,
   input  logic                                wr,
   output logic [mem_sys_pkg::data_width-1:0]  data_out,
   output logic                                done,
   output logic                                stall,
   output logic                                cache_hit,
   output logic                                err
);
   import mem_sys_pkg::*;

   logic                    enable;
   logic                    comp;
   logic                    write0;
   logic                    write1;
   logic [tag_width-1:0]    tag_in;
   logic [index_width-1:0]  index;
   logic [offset_width-1:0] offset;
   logic [data_width-1:0]   cache_data_in;
   logic [tag_width-1:0]    tag_out0;
   logic [tag_width-1:0]    tag_out1;
   logic [data_width-1:0]   data_out0;
   logic [data_width-1:0]   data_out1;
   logic                    hit0;
   logic                    hit1;
   logic                    dirty0;
   logic                    dirty1;
   logic                    valid0;
   logic                    valid1;
   logic [addr_width-1:0]   mem_addr;
   logic [data_width-1:0]   mem_data_in;
   logic [data_width-1:0]   mem_data_out;
   logic                    mem_rd;
   logic                    mem_wr;
   logic                    mem_stall;

   cache_way way0 (
      .clk           (clk),
      .reset         (reset),
      .enable        (enable),
      .comp          (comp),
      .write         (write0),
      .tag_in        (tag_in),
      .index         (index),
      .offset        (offset),
      .cache_data_in (cache_data_in),
      .tag_out       (tag_out0),
      .data_out      (data_out0),
      .hit           (hit0),
      .dirty         (dirty0),
      .valid         (valid0)
   );

   cache_way way1 (
      .clk           (clk),
      .reset         (reset),
      .enable        (enable),
      .comp          (comp),
      .write         (write1),
      .tag_in        (tag_in),
      .index         (index),
      .offset        (offset),
      .cache_data_in (cache_data_in),
      .tag_out       (tag_out1),
      .data_out      (data_out1),
      .hit           (hit1),
      .dirty         (dirty1),
      .valid         (valid1)
   );

   cache_controller ctrl (
      .clk           (clk),
      .reset         (reset),
      .addr          (addr),
      .data_in       (data_in),
      .rd            (rd),
      .wr            (wr),
      .tag_out0      (tag_out0),
      .data_out0     (data_out0),
      .hit0          (hit0),
      .dirty0        (dirty0),
      .valid0        (valid0),
      .tag_out1      (tag_out1),
      .data_out1     (data_out1),
      .hit1          (hit1),
      .dirty1        (dirty1),
      .valid1        (valid1),
      .mem_data_out  (mem_data_out),
      .mem_stall     (mem_stall),
      .enable        (enable),
      .comp          (comp),
      .write0        (write0),
      .write1        (write1),
      .tag_in        (tag_in),
      .index         (index),
      .offset        (offset),
      .cache_data_in (cache_data_in),
      .mem_addr      (mem_addr),
      .mem_data_in   (mem_data_in),
      .mem_rd        (mem_rd),
      .mem_wr        (mem_wr),
      .data_out      (data_out),
      .done          (done),
      .stall         (stall),
      .cache_hit     (cache_hit),
      .err           (err)
   );

   bank_memory mem (
      .clk          (clk),
      .reset        (reset),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_rd       (mem_rd),
      .mem_wr       (mem_wr),
      .mem_data_out (mem_data_out),
      .mem_stall    (mem_stall)
   );

endmodule

// File: test/mem_system_assert.sv
// Client-side protocol checks for the memory system.
// Bound to mem_system from the testbench; failures show up as assertion errors.

`timescale 1ns/10ps

module mem_system_assert (
   input logic clk,
   input logic reset,
   input logic done,
   input logic stall,
   input logic cache_hit,
   input logic err
);

   // done is a single-cycle pulse
   done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
      else $error("done stayed high for two cycles in a row");

   no_stall_at_done: assert property (@(posedge clk) disable iff (reset) done |-> !stall)
      else $error("stall high in the done cycle");

   // err and cache_hit only qualify a done cycle
   err_with_done: assert property (@(posedge clk) disable iff (reset) err |-> done)
      else $error("err high without done");

   hit_with_done: assert property (@(posedge clk) disable iff (reset) cache_hit |-> done)
      else $error("cache_hit high without done");

endmodule

// File: test/mem_system_tb.sv
// Testbench for the data memory system. Sends directed and LCG-driven
// requests, predicts data_out, cache_hit and err from a reference model of
// the cache tags and main memory, and prints one line per test.

`timescale 1ns/10ps

module mem_system_tb;
   import mem_sys_pkg::*;

   localparam int clk_period   = 40;
   localparam int reset_cycles = 4;
   localparam int num_random   = 400;
   // Directed tests use at most 22 requests
   localparam int max_requests = 22 + num_random;
   localparam int watchdog_ns  = (max_requests * 60 + reset_cycles + 10) * clk_period;

   logic                  clk;
   logic                  reset;
   logic [addr_width-1:0] addr;
   logic [data_width-1:0] data_in;
   logic                  rd;
   logic                  wr;
   logic [data_width-1:0] data_out;
   logic                  done;
   logic                  stall;
   logic                  cache_hit;
   logic                  err;

   // Reference model with a flat memory image and the tag state of both ways
   logic [data_width-1:0] model_mem   [mem_words];
   logic [tag_width-1:0]  model_tag   [num_sets][2];
   logic                  model_valid [num_sets][2];
   logic                  model_victim;

   logic [31:0]           lcg_state;
   int                    errors;
   int                    checks;
   int                    test_errors;
   int                    latency;
   logic                  got_hit;
   logic                  got_err;
   logic [data_width-1:0] got_data;

   mem_system dut (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   bind mem_system mem_system_assert chk (
      .clk       (clk),
      .reset     (reset),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #(clk_period / 2) clk = ~clk;

   initial begin
      #(watchdog_ns);
      $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
      $display("Simulation failed");
      $finish;
   end

   function automatic logic [31:0] rand_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [addr_width-1:0] make_addr(input logic [tag_width-1:0] t,
                                                      input logic [index_width-1:0] s,
                                                      input logic [1:0] w);
      return {t, s, w, 1'b0};
   endfunction

   task automatic count_error();
      errors++;
      test_errors++;
   endtask

   // Predicts one access and updates tags, victim bit and memory image
   task automatic model_access(input logic [addr_width-1:0] a, input logic [data_width-1:0] d,
                               input logic r, input logic w, output logic exp_err,
                               output logic exp_hit, output logic [data_width-1:0] exp_data);
      logic [tag_width-1:0]   t;
      logic [index_width-1:0] s;
      logic                   way;
      t = a[addr_width-1 -: tag_width];
      s = a[3 +: index_width];
      exp_err  = (r && w) || a[0];
      exp_hit  = 1'b0;
      exp_data = model_mem[a[addr_width-1:1]];
      if (!exp_err) begin
         for (int k = 0; k < 2; k++) begin
            if (model_valid[s][k] && model_tag[s][k] == t) begin
               exp_hit = 1'b1;
            end
         end
         if (!exp_hit) begin
            way = !model_valid[s][0] ? 1'b0 : (!model_valid[s][1] ? 1'b1 : model_victim);
            model_tag[s][way]   = t;
            model_valid[s][way] = 1'b1;
         end
         if (w) begin
            model_mem[a[addr_width-1:1]] = d;
         end
         model_victim = ~model_victim;
      end
   endtask

   // Called 2 ns after a rising edge; returns at the same point after done
   task automatic run_request(input logic [addr_width-1:0] a, input logic [data_width-1:0] d,
                              input logic r, input logic w);
      int cyc;
      addr    = a;
      data_in = d;
      rd      = r;
      wr      = w;
      cyc     = 0;
      @(negedge clk);
      while (!done) begin
         if (stall !== (cyc > 0)) begin
            count_error();
            $display("Fail stall at addr %h cycle %0d: got %h expected %h", a, cyc, stall,
                     cyc > 0);
         end
         cyc++;
         @(negedge clk);
      end
      latency  = cyc;
      got_hit  = cache_hit;
      got_err  = err;
      got_data = data_out;
      @(posedge clk);
      #2;
      rd = 1'b0;
      wr = 1'b0;
   endtask

   task automatic expect_response(input logic [addr_width-1:0] a,
                                  input logic [data_width-1:0] d, input logic r, input logic w);
      logic                  exp_err;
      logic                  exp_hit;
      logic [data_width-1:0] exp_data;
      model_access(a, d, r, w, exp_err, exp_hit, exp_data);
      run_request(a, d, r, w);
      checks++;
      if (got_err !== exp_err) begin
         count_error();
         $display("Fail err at addr %h: got %h expected %h", a, got_err, exp_err);
      end
      if (got_hit !== exp_hit) begin
         count_error();
         $display("Fail cache_hit at addr %h: got %h expected %h", a, got_hit, exp_hit);
      end
      if (r && !exp_err && got_data !== exp_data) begin
         count_error();
         $display("Fail data_out at addr %h: got %h expected %h", a, got_data, exp_data);
      end
      if ((exp_err && latency != 1) || (exp_hit && latency != 2)) begin
         count_error();
         $display("Fail done latency at addr %h: got %0h expected %0h", a, latency,
                  exp_err ? 1 : 2);
      end
      if (!exp_err && !exp_hit && latency <= 2) begin
         count_error();
         $display("Miss at addr %h finished after only %0d cycles", a, latency);
      end
   endtask

   task automatic report_test(input int num, input string name);
      if (test_errors == 0) begin
         $display("Test %0d %s: ok", num, name);
      end else begin
         $display("Test %0d %s: %0d errors", num, name, test_errors);
      end
      test_errors = 0;
   endtask

   initial begin
      logic [31:0]           r;
      logic [31:0]           rv;
      logic [data_width-1:0] d0;
      logic [addr_width-1:0] a;
      logic                  t0_way;
      clk          = 1'b0;
      reset        = 1'b1;
      addr         = '0;
      data_in      = '0;
      rd           = 1'b0;
      wr           = 1'b0;
      lcg_state    = 32'ha7d5_af40;
      errors       = 0;
      checks       = 0;
      test_errors  = 0;
      model_victim = 1'b0;
      for (int i = 0; i < mem_words; i++) begin
         model_mem[i] = '0;
      end
      for (int s = 0; s < num_sets; s++) begin
         model_valid[s][0] = 1'b0;
         model_valid[s][1] = 1'b0;
      end
      repeat (reset_cycles) @(posedge clk);
      #2;
      reset = 1'b0;

      // Idle outputs, then cold reads of zeroed memory
      @(negedge clk);
      if (stall !== 1'b0) begin
         count_error();
         $display("Fail stall after reset: got %h expected 0", stall);
      end
      if (done !== 1'b0) begin
         count_error();
         $display("Fail done after reset: got %h expected 0", done);
      end
      if (err !== 1'b0) begin
         count_error();
         $display("Fail err after reset: got %h expected 0", err);
      end
      @(posedge clk);
      #2;
      expect_response(16'h0000, 16'h0000, 1'b1, 1'b0);
      expect_response(16'h1a28, 16'h0000, 1'b1, 1'b0);
      expect_response(16'hfffe, 16'h0000, 1'b1, 1'b0);
      expect_response(16'h4c16, 16'h0000, 1'b1, 1'b0);
      report_test(1, "reset and cold reads");

      for (int i = 0; i < 4; i++) begin
         r  = rand_next();
         rv = rand_next();
         a  = make_addr(r[31:27], {2'b00, r[26:21]}, r[20:19]);
         expect_response(a, rv[31:16], 1'b0, 1'b1);
         expect_response(a, 16'h0000, 1'b1, 1'b0);
      end
      report_test(2, "write then read hit");

      // Three tags in set 0x5a; the first tag's way is made the victim
      rv = rand_next();
      expect_response(make_addr(5'h03, 8'h5a, 2'd1), rv[31:16], 1'b0, 1'b1);
      expect_response(make_addr(5'h0b, 8'h5a, 2'd1), rv[15:0], 1'b0, 1'b1);
      t0_way = model_valid[8'h5a][1] && (model_tag[8'h5a][1] == 5'h03);
      if (model_victim != t0_way) begin
         expect_response(make_addr(5'h03, 8'h5a, 2'd1), 16'h0000, 1'b1, 1'b0);
      end
      rv = rand_next();
      expect_response(make_addr(5'h16, 8'h5a, 2'd1), rv[31:16], 1'b0, 1'b1);
      expect_response(make_addr(5'h03, 8'h5a, 2'd1), 16'h0000, 1'b1, 1'b0);
      if (got_hit !== 1'b0) begin
         count_error();
         $display("Fail cache_hit on reread of the evicted tag: got %h expected 0", got_hit);
      end
      report_test(3, "dirty eviction");

      a  = make_addr(5'h1c, 8'h77, 2'd2);
      rv = rand_next();
      d0 = rv[31:16];
      expect_response(a, d0, 1'b0, 1'b1);
      expect_response(a | 16'h0001, 16'h0000, 1'b1, 1'b0);
      expect_response(a | 16'h0001, ~d0, 1'b0, 1'b1);
      expect_response(a, ~d0, 1'b1, 1'b1);
      expect_response(a, 16'h0000, 1'b1, 1'b0);
      report_test(4, "error requests");

      // Four tags over four sets keep both ways busy
      for (int i = 0; i < num_random; i++) begin
         r  = rand_next();
         rv = rand_next();
         a  = make_addr({r[29:28], 3'b101}, {r[27:26], 6'h1a}, r[25:24]);
         expect_response(a, rv[31:16], !r[31], r[31]);
      end
      report_test(5, "random traffic");

      $display("Tests: 5, checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: mem_system.f
hw/mem_sys_pkg.sv
hw/cache_way.sv
hw/bank_memory.sv
hw/cache_controller.sv
hw/mem_system.sv
test/mem_system_assert.sv
test/mem_system_tb.sv

// File: Makefile
# Verilator simulation of the two-way cache memory system

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0 --timescale 1ns/10ps
TOP       := mem_system_tb
FILELIST  := mem_system.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail if the log reports a failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then \
	   echo "TEST FAILED"; exit 1; \
	fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
